// File: hw/core_types_pkg.sv
// Words and flags are fixed at 32 bits and register indices at 6 bits, so at most 64 physical registers.
`default_nettype none

package core_types_pkg;

        // Data and PC word.
        typedef logic [31:0] word_t;

        // Condition flag word, kept as wide as a data word.
        typedef logic [31:0] flags_t;

        // Width of a physical register index.
        localparam int PHY_IDX_W = 6;

        // Physical register index.
        typedef logic [PHY_IDX_W-1:0] phy_idx_t;

        // Index 0 reads as zero. Use it when no write is wanted.
        localparam phy_idx_t RAZ_INDEX = '0;

        // Exception vector addresses.
        // Undefined instruction.
        localparam word_t VEC_UND  = 32'h0000_0004;
        // Software interrupt.
        localparam word_t VEC_SWI  = 32'h0000_0008;
        // Prefetch abort.
        localparam word_t VEC_PABT = 32'h0000_000C;
        // Normal interrupt.
        localparam word_t VEC_IRQ  = 32'h0000_0018;
        // Fast interrupt, last in the table.
        localparam word_t VEC_FIQ  = 32'h0000_001C;

endpackage

`default_nettype wire

// File: hw/pipe_pkg.sv
// Bundle layout is shared by the execute output and the memory stage output, so both sides must agree.
`default_nettype none

package pipe_pkg;

        // Exception flags that travel with an instruction.
        typedef struct packed {
                logic irq;
                logic fiq;
                logic instr_abort;
                logic swi;
                logic und;
        } exc_bits_t;

        // Everything one instruction carries from execute into writeback.
        typedef struct packed {
                logic                      dav;
                core_types_pkg::word_t     alu_result;
                core_types_pkg::flags_t    flags;
                logic                      flag_update;
                core_types_pkg::phy_idx_t  destination_index;
                logic                      mem_load;
                // Target of a load, RAZ when unused.
                core_types_pkg::phy_idx_t  mem_srcdest_index;
                core_types_pkg::word_t     pc_plus_8;
                exc_bits_t                 exc;
                // Data memory read result for this instruction.
                core_types_pkg::word_t     mem_rd_data;
        } stage_bundle_t;

        // Resolved exception cause, reported with the redirect.
        typedef enum logic [2:0] {
                NONE = 3'd0,
                FIQ  = 3'd1,
                IRQ  = 3'd2,
                PABT = 3'd3,
                UND  = 3'd4,
                SWI  = 3'd5
        } exc_cause_e;

        // Writeback control states.
        typedef enum logic {
                RUN   = 1'b0,
                FLUSH = 1'b1
        } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/mem_stage_reg.sv
// Clear beats stall, and the upstream stage must hold its bundle for as long as i_stall is high.
`timescale 1ns/1ps
`default_nettype none

module mem_stage_reg
(
        // Clock and reset.
        input  wire logic                    i_clk,
        input  wire logic                    i_reset,

        // Pipeline control.
        input  wire logic                    i_clear,
        input  wire logic                    i_stall,

        // Bundle from execute, memory read data included.
        input  wire pipe_pkg::stage_bundle_t i_bundle,

        // Bundle towards writeback.
        output pipe_pkg::stage_bundle_t      o_bundle
);

        // The memory gets a whole cycle here, so throughput is kept.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_bundle <= '0;
                end
                else if (i_clear)
                begin
                        // Kill whatever would be captured.
                        o_bundle <= '0;
                end
                else if (i_stall)
                begin
                        // Hold.
                        o_bundle <= o_bundle;
                end
                else
                begin
                        o_bundle <= i_bundle;
                end
        end

endmodule

`default_nettype wire

// File: hw/pipe_ctrl.sv
// Resolves one exception at a time; the redirect is a single-cycle pulse and nothing can follow it.
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl
(
        // Clock and reset.
        input  wire logic                    i_clk,
        input  wire logic                    i_reset,

        // Instruction sitting in the memory stage.
        input  wire pipe_pkg::stage_bundle_t i_stage,
        input  wire logic                    i_data_stall,

        // Clear to the memory stage.
        output logic                         o_clear,

        // Register file write enables.
        output logic                         o_alu_we,
        output logic                         o_load_we,
        output logic                         o_flag_we,

        // Redirect to the exception vector.
        output logic                         o_redirect_valid,
        output core_types_pkg::word_t        o_redirect_pc,
        output pipe_pkg::exc_cause_e         o_exc_cause
);

        logic                   exc_any;
        logic                   commit;
        logic                   take_exc;
        pipe_pkg::exc_cause_e   cause_d;
        core_types_pkg::word_t  vec_d;
        pipe_pkg::ctrl_state_e  state_q;
        pipe_pkg::ctrl_state_e  state_d;

        assign exc_any = |i_stage.exc;

        // A valid instruction with an exception kills itself and the one behind it.
        assign o_clear = i_stage.dav && exc_any;

        // Only a clean, valid, unstalled instruction may write.
        assign commit = i_stage.dav && !exc_any && !i_data_stall;

        assign o_alu_we  = commit && (i_stage.destination_index != core_types_pkg::RAZ_INDEX);
        assign o_load_we = commit && i_stage.mem_load &&
                           (i_stage.mem_srcdest_index != core_types_pkg::RAZ_INDEX);
        assign o_flag_we = commit && i_stage.flag_update;

        // Priority is FIQ, IRQ, PABT, UND, SWI.
        always_comb
        begin
                cause_d = pipe_pkg::NONE;
                vec_d   = '0;
                if (i_stage.exc.fiq)
                begin
                        cause_d = pipe_pkg::FIQ;
                        vec_d   = core_types_pkg::VEC_FIQ;
                end
                else if (i_stage.exc.irq)
                begin
                        cause_d = pipe_pkg::IRQ;
                        vec_d   = core_types_pkg::VEC_IRQ;
                end
                else if (i_stage.exc.instr_abort)
                begin
                        cause_d = pipe_pkg::PABT;
                        vec_d   = core_types_pkg::VEC_PABT;
                end
                else if (i_stage.exc.und)
                begin
                        cause_d = pipe_pkg::UND;
                        vec_d   = core_types_pkg::VEC_UND;
                end
                else if (i_stage.exc.swi)
                begin
                        cause_d = pipe_pkg::SWI;
                        vec_d   = core_types_pkg::VEC_SWI;
                end
        end

        // No second redirect while flushing.
        assign take_exc = (state_q == pipe_pkg::RUN) && o_clear;

        always_comb
        begin
                case (state_q)
                        pipe_pkg::RUN:   state_d = take_exc ? pipe_pkg::FLUSH : pipe_pkg::RUN;
                        pipe_pkg::FLUSH: state_d = pipe_pkg::RUN;
                        default:         state_d = pipe_pkg::RUN;
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q          <= pipe_pkg::RUN;
                        o_redirect_valid <= 1'b0;
                        o_redirect_pc    <= '0;
                        o_exc_cause      <= pipe_pkg::NONE;
                end
                else
                begin
                        state_q          <= state_d;
                        o_redirect_valid <= take_exc;
                        if (take_exc)
                        begin
                                o_redirect_pc <= vec_d;
                                o_exc_cause   <= cause_d;
                        end
                end
        end

endmodule

`default_nettype wire

// File: hw/phys_reg_file.sv
// PHY_REGS may not exceed 64; index 0 and indices at or above PHY_REGS read zero and drop writes.
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file
#(
        // Number of physical registers.
        parameter int PHY_REGS = 46
)
(
        // Clock and reset.
        input  wire logic                     i_clk,
        input  wire logic                     i_reset,

        // ALU write port.
        input  wire logic                     i_alu_we,
        input  wire core_types_pkg::phy_idx_t i_alu_index,
        input  wire core_types_pkg::word_t    i_alu_data,

        // Load write port, wins over the ALU port.
        input  wire logic                     i_load_we,
        input  wire core_types_pkg::phy_idx_t i_load_index,
        input  wire core_types_pkg::word_t    i_load_data,

        // Flag write.
        input  wire logic                     i_flag_we,
        input  wire core_types_pkg::flags_t   i_flags,

        // Combinational read port.
        input  wire core_types_pkg::phy_idx_t i_rd_index,
        output core_types_pkg::word_t         o_rd_data,
        output core_types_pkg::flags_t        o_flags
);

        core_types_pkg::word_t regs [PHY_REGS];
        logic                  alu_ok;
        logic                  load_ok;

        assign alu_ok  = i_alu_we && (i_alu_index != core_types_pkg::RAZ_INDEX) &&
                         (i_alu_index < PHY_REGS);
        assign load_ok = i_load_we && (i_load_index != core_types_pkg::RAZ_INDEX) &&
                         (i_load_index < PHY_REGS);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < PHY_REGS; i++)
                        begin
                                regs[i] <= '0;
                        end
                        o_flags <= '0;
                end
                else
                begin
                        if (alu_ok)
                                regs[i_alu_index] <= i_alu_data;
                        // Later assignment, so the load takes a shared index.
                        if (load_ok)
                                regs[i_load_index] <= i_load_data;
                        if (i_flag_we)
                                o_flags <= i_flags;
                end
        end

        always_comb
        begin
                if ((i_rd_index == core_types_pkg::RAZ_INDEX) || (i_rd_index >= PHY_REGS))
                        o_rd_data = '0;
                else
                        o_rd_data = regs[i_rd_index];
        end

endmodule

`default_nettype wire

// File: hw/backend_top.sv
// Source must hold i_ex_bundle while i_data_stall is high; read-back sees a write two edges after capture.
`timescale 1ns/1ps
`default_nettype none

module backend_top
#(
        // Number of physical registers, 64 at most.
        parameter int PHY_REGS = 46
)
(
        // Clock and reset.
        input  wire logic                     i_clk,
        input  wire logic                     i_reset,

        // Execute results and memory read data.
        input  wire pipe_pkg::stage_bundle_t  i_ex_bundle,
        input  wire logic                     i_data_stall,

        // Register read-back.
        input  wire core_types_pkg::phy_idx_t i_rd_index,
        output core_types_pkg::word_t         o_rd_data,
        output core_types_pkg::flags_t        o_flags,

        // Exception redirect.
        output logic                          o_redirect_valid,
        output core_types_pkg::word_t         o_redirect_pc,
        output pipe_pkg::exc_cause_e          o_exc_cause
);

        pipe_pkg::stage_bundle_t stage_q;
        logic                    clear;
        logic                    alu_we;
        logic                    load_we;
        logic                    flag_we;

        mem_stage_reg u_mem_stage_reg
        (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_clear  (clear),
                .i_stall  (i_data_stall),
                .i_bundle (i_ex_bundle),
                .o_bundle (stage_q)
        );

        pipe_ctrl u_pipe_ctrl
        (
                .i_clk            (i_clk),
                .i_reset          (i_reset),
                .i_stage          (stage_q),
                .i_data_stall     (i_data_stall),
                .o_clear          (clear),
                .o_alu_we         (alu_we),
                .o_load_we        (load_we),
                .o_flag_we        (flag_we),
                .o_redirect_valid (o_redirect_valid),
                .o_redirect_pc    (o_redirect_pc),
                .o_exc_cause      (o_exc_cause)
        );

        phys_reg_file #(.PHY_REGS(PHY_REGS)) u_phys_reg_file
        (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_alu_we     (alu_we),
                .i_alu_index  (stage_q.destination_index),
                .i_alu_data   (stage_q.alu_result),
                .i_load_we    (load_we),
                .i_load_index (stage_q.mem_srcdest_index),
                .i_load_data  (stage_q.mem_rd_data),
                .i_flag_we    (flag_we),
                .i_flags      (stage_q.flags),
                .i_rd_index   (i_rd_index),
                .o_rd_data    (o_rd_data),
                .o_flags      (o_flags)
        );

endmodule

`default_nettype wire

// File: verification/backend_chk.sv
// Bound to backend_top; assertions are disabled while i_reset is high except the reset check.
`timescale 1ns/1ps
`default_nettype none

module backend_chk
(
        input wire logic                    i_clk,
        input wire logic                    i_reset,
        input wire logic                    i_clear,
        input wire logic                    i_stall,
        input wire logic                    i_alu_we,
        input wire logic                    i_load_we,
        input wire logic                    i_flag_we,
        input wire logic                    i_redirect_valid,
        input wire pipe_pkg::stage_bundle_t i_stage
);

        // A killed instruction never writes.
        a_clear_no_write: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |-> !(i_alu_we || i_load_we || i_flag_we))
                else $error("write enable raised together with clear");

        // Redirect is a single-cycle pulse.
        a_redirect_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
                i_redirect_valid |=> !i_redirect_valid)
                else $error("redirect valid high for two cycles");

        // Stage register holds during a stall.
        a_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stall && !i_clear) |=> $stable(i_stage))
                else $error("stage register changed during stall");

        a_reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> !i_redirect_valid)
                else $error("redirect valid high after reset");

endmodule

bind backend_top backend_chk u_backend_chk
(
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clear          (clear),
        .i_stall          (i_data_stall),
        .i_alu_we         (alu_we),
        .i_load_we        (load_we),
        .i_flag_we        (flag_we),
        .i_redirect_valid (o_redirect_valid),
        .i_stage          (stage_q)
);

`default_nettype wire

// File: verification/backend_tb.sv
// Drives backend_top with PHY_REGS of 46 and checks it against a cycle model of the writeback rules.
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

        localparam int          PHY_REGS = 46;
        localparam int          TIMEOUT  = 16;
        // Exception bit order is irq, fiq, instr_abort, swi, und.
        localparam logic [4:0]  E_IRQ    = 5'b10000;
        localparam logic [4:0]  E_FIQ    = 5'b01000;
        localparam logic [4:0]  E_PABT   = 5'b00100;
        localparam logic [4:0]  E_SWI    = 5'b00010;
        localparam logic [4:0]  E_UND    = 5'b00001;

        typedef struct packed {
                pipe_pkg::stage_bundle_t b;
                logic                    stall;
        } row_t;

        logic                     i_clk;
        logic                     i_reset;
        pipe_pkg::stage_bundle_t  i_ex_bundle;
        logic                     i_data_stall;
        core_types_pkg::phy_idx_t i_rd_index;
        core_types_pkg::word_t    o_rd_data;
        core_types_pkg::flags_t   o_flags;
        logic                     o_redirect_valid;
        core_types_pkg::word_t    o_redirect_pc;
        pipe_pkg::exc_cause_e     o_exc_cause;

        row_t                     rows[$];
        logic [31:0]              lcg_state;
        int                       value_errors;
        int                       timeout_errors;

        // Reference model state.
        pipe_pkg::stage_bundle_t  m_stage;
        logic                     m_flush;
        core_types_pkg::word_t    m_regs [64];
        core_types_pkg::flags_t   m_flags;
        logic                     exp_valid;
        core_types_pkg::word_t    exp_pc;
        pipe_pkg::exc_cause_e     exp_cause;

        backend_top #(.PHY_REGS(PHY_REGS)) UUT
        (
                .i_clk            (i_clk),
                .i_reset          (i_reset),
                .i_ex_bundle      (i_ex_bundle),
                .i_data_stall     (i_data_stall),
                .i_rd_index       (i_rd_index),
                .o_rd_data        (o_rd_data),
                .o_flags          (o_flags),
                .o_redirect_valid (o_redirect_valid),
                .o_redirect_pc    (o_redirect_pc),
                .o_exc_cause      (o_exc_cause)
        );

        always #2 i_clk = ~i_clk;

        function logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        // Builds a bundle with random data fields.
        function pipe_pkg::stage_bundle_t make_bundle(input logic dav, input logic [5:0] dest,
                input logic load, input logic [5:0] src, input logic fu, input logic [4:0] e);
                pipe_pkg::stage_bundle_t b;
                b                   = '0;
                b.dav               = dav;
                b.alu_result        = lcg_next();
                b.flags             = lcg_next();
                b.flag_update       = fu;
                b.destination_index = dest;
                b.mem_load          = load;
                b.mem_srcdest_index = src;
                b.pc_plus_8         = lcg_next();
                b.exc               = e;
                b.mem_rd_data       = lcg_next();
                return b;
        endfunction

        task automatic add_row(input pipe_pkg::stage_bundle_t b, input logic s);
                row_t r;
                r.b     = b;
                r.stall = s;
                rows.push_back(r);
        endtask

        function core_types_pkg::word_t expected_read(input logic [5:0] idx);
                if ((idx == 6'd0) || (idx >= PHY_REGS))
                        return '0;
                return m_regs[idx];
        endfunction

        // Advances the model by one rising edge with inputs b and s.
        task automatic model_step(input pipe_pkg::stage_bundle_t b, input logic s);
                logic       clr;
                logic [4:0] e;
                e   = m_stage.exc;
                clr = m_stage.dav && (e != 5'd0);
                if (m_stage.dav && (e == 5'd0) && !s)
                begin
                        if ((m_stage.destination_index != 0) &&
                            (m_stage.destination_index < PHY_REGS))
                                m_regs[m_stage.destination_index] = m_stage.alu_result;
                        // Load is applied last, so it wins a shared index.
                        if (m_stage.mem_load && (m_stage.mem_srcdest_index != 0) &&
                            (m_stage.mem_srcdest_index < PHY_REGS))
                                m_regs[m_stage.mem_srcdest_index] = m_stage.mem_rd_data;
                        if (m_stage.flag_update)
                                m_flags = m_stage.flags;
                end
                exp_valid = !m_flush && clr;
                if (exp_valid)
                begin
                        if (e & E_FIQ)
                                exp_cause = pipe_pkg::FIQ;
                        else if (e & E_IRQ)
                                exp_cause = pipe_pkg::IRQ;
                        else if (e & E_PABT)
                                exp_cause = pipe_pkg::PABT;
                        else if (e & E_UND)
                                exp_cause = pipe_pkg::UND;
                        else
                                exp_cause = pipe_pkg::SWI;
                        // Vector addresses of the exception table.
                        case (exp_cause)
                                pipe_pkg::FIQ:  exp_pc = 32'h1C;
                                pipe_pkg::IRQ:  exp_pc = 32'h18;
                                pipe_pkg::PABT: exp_pc = 32'h0C;
                                pipe_pkg::UND:  exp_pc = 32'h04;
                                default:        exp_pc = 32'h08;
                        endcase
                end
                m_flush = exp_valid;
                if (clr)
                        m_stage = '0;
                else if (!s)
                        m_stage = b;
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        value_errors++;
                end
        endtask

        task automatic check_word(input string name, input core_types_pkg::word_t got,
                input core_types_pkg::word_t exp);
                if (got !== exp)
                begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        value_errors++;
                end
        endtask

        task automatic check_flags(input string name, input core_types_pkg::flags_t got,
                input core_types_pkg::flags_t exp);
                if (got !== exp)
                begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        value_errors++;
                end
        endtask

        task automatic check_cause(input string name, input pipe_pkg::exc_cause_e got,
                input pipe_pkg::exc_cause_e exp);
                if (got !== exp)
                begin
                        $display("FAILED %s: got %h expected %h", name, got, exp);
                        value_errors++;
                end
        endtask

        // Checks what the last edge produced and then drives the next inputs.
        task automatic run_cycle(input pipe_pkg::stage_bundle_t b, input logic s);
                @(negedge i_clk);
                check_bit("o_redirect_valid", o_redirect_valid, exp_valid);
                if (exp_valid)
                begin
                        check_word("o_redirect_pc", o_redirect_pc, exp_pc);
                        check_cause("o_exc_cause", o_exc_cause, exp_cause);
                end
                check_flags("o_flags", o_flags, m_flags);
                check_word("o_rd_data", o_rd_data, expected_read(i_rd_index));
                i_ex_bundle  = b;
                i_data_stall = s;
                // Read back the register that the stage writes at the coming edge.
                if (m_stage.mem_load)
                        i_rd_index = m_stage.mem_srcdest_index;
                else
                        i_rd_index = m_stage.destination_index;
                model_step(b, s);
        endtask

        task automatic wait_redirect(input pipe_pkg::exc_cause_e cause);
                int n;
                n = 0;
                while (!o_redirect_valid && (n < TIMEOUT))
                begin
                        run_cycle('0, 1'b0);
                        n++;
                end
                if (o_redirect_valid)
                        check_cause("o_exc_cause", o_exc_cause, cause);
                else
                begin
                        $display("Timed out waiting for the redirect pulse");
                        timeout_errors++;
                end
        endtask

        task automatic build_table();
                pipe_pkg::stage_bundle_t b;
                logic [4:0]              causes [5];
                causes = '{E_FIQ, E_IRQ, E_PABT, E_UND, E_SWI};
                // ALU writes with flags updated on odd indices only.
                for (int i = 1; i <= 8; i++)
                        add_row(make_bundle(1'b1, 6'(i), 1'b0, 6'd0, i[0], 5'd0), 1'b0);
                // Loads including a shared index and writes to index 0.
                add_row(make_bundle(1'b1, 6'd0, 1'b1, 6'd10, 1'b0, 5'd0), 1'b0);
                add_row(make_bundle(1'b1, 6'd12, 1'b1, 6'd12, 1'b1, 5'd0), 1'b0);
                add_row(make_bundle(1'b1, 6'd0, 1'b1, 6'd0, 1'b0, 5'd0), 1'b0);
                // A bundle held across two stall cycles.
                b = make_bundle(1'b1, 6'd14, 1'b1, 6'd15, 1'b1, 5'd0);
                add_row(b, 1'b1);
                add_row(b, 1'b1);
                add_row(b, 1'b0);
                add_row(make_bundle(1'b1, 6'd16, 1'b0, 6'd0, 1'b0, 5'd0), 1'b1);
                add_row(make_bundle(1'b1, 6'd17, 1'b0, 6'd0, 1'b0, 5'd0), 1'b0);
                // Each cause alone is followed by a row that must be discarded.
                for (int c = 0; c < 5; c++)
                begin
                        add_row(make_bundle(1'b1, 6'(20 + c), 1'b1, 6'(25 + c), 1'b1,
                                causes[c]), 1'b0);
                        add_row(make_bundle(1'b1, 6'(30 + c), 1'b1, 6'(35 + c), 1'b1, 5'd0),
                                1'b0);
                        add_row('0, 1'b0);
                end
                // Several causes in one row.
                add_row(make_bundle(1'b1, 6'd40, 1'b0, 6'd0, 1'b0, E_FIQ | E_SWI), 1'b0);
                add_row('0, 1'b0);
                add_row(make_bundle(1'b1, 6'd41, 1'b0, 6'd0, 1'b0, E_IRQ | E_UND | E_PABT),
                        1'b0);
                add_row('0, 1'b0);
                add_row(make_bundle(1'b1, 6'd42, 1'b0, 6'd0, 1'b0, E_UND | E_SWI), 1'b0);
                add_row('0, 1'b0);
                // Invalid row with exception bits set.
                add_row(make_bundle(1'b0, 6'd43, 1'b1, 6'd44, 1'b1, E_IRQ | E_SWI), 1'b0);
                // Random rows include indices past PHY_REGS.
                for (int i = 0; i < 24; i++)
                        add_row(make_bundle(1'b1, 6'(lcg_next()), lcg_next() > 32'h8000_0000,
                                6'(lcg_next()), lcg_next() > 32'h8000_0000, 5'd0),
                                lcg_next() > 32'hC000_0000);
                add_row('0, 1'b0);
                add_row('0, 1'b0);
        endtask

        initial
        begin
                i_clk          = 1'b0;
                i_reset        = 1'b1;
                i_ex_bundle    = '0;
                i_data_stall   = 1'b0;
                i_rd_index     = '0;
                lcg_state      = 32'd50192;
                value_errors   = 0;
                timeout_errors = 0;
                m_stage        = '0;
                m_flush        = 1'b0;
                m_flags        = '0;
                exp_valid      = 1'b0;
                exp_pc         = '0;
                exp_cause      = pipe_pkg::NONE;
                for (int i = 0; i < 64; i++)
                        m_regs[i] = '0;
                build_table();
                repeat (10) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;

                foreach (rows[i])
                        run_cycle(rows[i].b, rows[i].stall);

                // Redirect found by waiting on the pulse.
                run_cycle(make_bundle(1'b1, 6'd5, 1'b0, 6'd0, 1'b1, E_UND), 1'b0);
                run_cycle(make_bundle(1'b1, 6'd6, 1'b0, 6'd0, 1'b1, 5'd0), 1'b0);
                wait_redirect(pipe_pkg::UND);
                run_cycle('0, 1'b0);
                run_cycle('0, 1'b0);

                // Sweep every index.
                for (int i = 0; i < 64; i++)
                begin
                        @(negedge i_clk);
                        i_rd_index = 6'(i);
                        #1;
                        check_word($sformatf("o_rd_data[%0d]", i), o_rd_data,
                                expected_read(6'(i)));
                end

                $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
                if ((value_errors == 0) && (timeout_errors == 0))
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

// File: build.f
hw/core_types_pkg.sv
hw/pipe_pkg.sv
hw/mem_stage_reg.sv
hw/pipe_ctrl.sv
hw/phys_reg_file.sv
hw/backend_top.sv
verification/backend_chk.sv
verification/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the backend testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
        --top-module backend_tb -Mdir "$OBJ" -f build.f
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator compile failed with status $status"
        exit 1
fi

"./$OBJ/Vbackend_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
        echo "Simulation passed"
        exit 0
else
        echo "Simulation failed, see $LOG"
        exit 1
fi
